// ==== hw/cache_defs.svh ====
// cache geometry macros.
// write-buffer depth.

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// log2 of words per line.
`define CACHE_LG_BLOCK_WORDS 2

// log2 of the number of indices.
`define CACHE_LG_SETS 4

// tag is what is left above index and byte offset.
`define CACHE_TAG_W (32 - `CACHE_LG_SETS - `CACHE_LG_BLOCK_WORDS - 2)

`define WB_DEPTH 4

`endif

// ==== hw/cache_pkg.sv ====
// cache-side types: request ops, address decode,
// lookup result and store commit.
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  typedef enum logic [2:0] {
    OP_LD     = 3'd0,
    OP_ST     = 3'd1,
    OP_TAGFL  = 3'd2,
    OP_AFL    = 3'd3,
    OP_AFLINV = 3'd4,
    OP_AINV   = 3'd5
  } cache_op_e;

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]            tag;
    logic [`CACHE_LG_SETS-1:0]          index;
    logic [`CACHE_LG_BLOCK_WORDS+1:0]   offset;
  } cache_addr_f_s;

  // tag bit 0 also picks the way for tagfl.
  typedef union packed {
    logic [31:0]   raw;
    cache_addr_f_s f;
  } cache_addr_u;

  typedef struct packed {
    logic                      valid;
    cache_op_e                 op;
    cache_addr_u               addr;
    logic [`CACHE_TAG_W-1:0]   tag0;
    logic [`CACHE_TAG_W-1:0]   tag1;
    logic                      valid0;
    logic                      valid1;
    logic                      dirty0;
    logic                      dirty1;
    logic                      mru;
    logic                      hit;
    logic                      hit_way;
  } lookup_s;

  typedef struct packed {
    logic                        valid;
    logic [`CACHE_LG_SETS-1:0]   index;
    logic                        way;
  } store_commit_s;

endpackage

`default_nettype wire

// ==== hw/dma_pkg.sv ====
// memory-side types: controller command and external beat.
`default_nettype none

package dma_pkg;

  // evict and fill are single-cycle strobes.
  typedef struct packed {
    logic        evict;
    logic        fill;
    logic [31:0] line_addr;
  } dma_cmd_s;

  // one word per beat, write set for evicts.
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [29:0] word_addr;
  } mem_beat_s;

endpackage

`default_nettype wire

// ==== hw/write_buffer.sv ====
// FIFO of committed stores.
// drains one entry per cycle into the status arrays.
`default_nettype none
`timescale 1ns/1ns

`include "cache_defs.svh"

module write_buffer import cache_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  input  store_commit_s push_i,
  output store_commit_s pop_o,
  output logic          empty_o
);

  localparam int PTR_W = $clog2(`WB_DEPTH);

  store_commit_s    mem_r [`WB_DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0]   count_r;
  logic             pop;

  assign empty_o = (count_r == '0);
  assign pop     = !empty_o;

  always_comb begin
    pop_o       = mem_r[rd_ptr_r];
    pop_o.valid = pop;
  end

  always_ff @(posedge clk_i) begin
    if (push_i.valid) begin
      mem_r[wr_ptr_r] <= push_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i.valid) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      count_r <= count_r + (PTR_W+1)'(push_i.valid) - (PTR_W+1)'(pop);
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    push_i.valid |-> (count_r != (PTR_W+1)'(`WB_DEPTH)));

endmodule

`default_nettype wire

// ==== hw/tag_status_mem.sv ====
// tag, valid, dirty and MRU arrays.
// registered two-way lookup with tag compare.
`default_nettype none
`timescale 1ns/1ns

`include "cache_defs.svh"

module tag_status_mem import cache_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        req_v_i,
  input  cache_op_e                   req_op_i,
  input  cache_addr_u                 req_addr_i,
  output lookup_s                     lookup_o,
  input  logic                        tag_we_i,
  input  logic                        inval_i,
  input  logic                        dirty_clr_i,
  input  logic                        touch_i,
  input  logic                        way_i,
  input  logic [`CACHE_LG_SETS-1:0]   index_i,
  input  logic [`CACHE_TAG_W-1:0]     tag_i,
  input  store_commit_s               wb_pop_i
);

  localparam int SETS = 1 << `CACHE_LG_SETS;

  logic [`CACHE_TAG_W-1:0] tags_r [2][SETS];
  logic [1:0]              valid_r [SETS];
  logic [1:0]              dirty_r [SETS];
  logic [SETS-1:0]         mru_r;

  logic                    lk_v_r;
  cache_op_e               lk_op_r;
  cache_addr_u             lk_addr_r;
  logic [`CACHE_TAG_W-1:0] lk_tag0_r;
  logic [`CACHE_TAG_W-1:0] lk_tag1_r;
  logic [1:0]              lk_valid_r;
  logic                    hit0;
  logic                    hit1;

  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tags_r[way_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < SETS; i++) begin
        valid_r[i] <= 2'b00;
        dirty_r[i] <= 2'b00;
      end
      mru_r <= '0;
    end else begin
      // drain first, controller updates below take priority.
      if (wb_pop_i.valid) begin
        dirty_r[wb_pop_i.index][wb_pop_i.way] <= 1'b1;
        mru_r[wb_pop_i.index]                 <= wb_pop_i.way;
      end
      if (tag_we_i) begin
        valid_r[index_i][way_i] <= 1'b1;
        dirty_r[index_i][way_i] <= 1'b0;
        mru_r[index_i]          <= way_i;
      end
      if (inval_i) begin
        valid_r[index_i][way_i] <= 1'b0;
        dirty_r[index_i][way_i] <= 1'b0;
      end
      if (dirty_clr_i) begin
        dirty_r[index_i][way_i] <= 1'b0;
      end
      if (touch_i) begin
        mru_r[index_i] <= way_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lk_v_r <= 1'b0;
    end else begin
      lk_v_r <= req_v_i;
    end
  end

  // request fields hold for the whole miss.
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      lk_op_r    <= req_op_i;
      lk_addr_r  <= req_addr_i;
      lk_tag0_r  <= tags_r[0][req_addr_i.f.index];
      lk_tag1_r  <= tags_r[1][req_addr_i.f.index];
      lk_valid_r <= valid_r[req_addr_i.f.index];
    end
  end

  assign hit0 = lk_valid_r[0] & (lk_tag0_r == lk_addr_r.f.tag);
  assign hit1 = lk_valid_r[1] & (lk_tag1_r == lk_addr_r.f.tag);

  // dirty and mru follow the live arrays so buffer drains are seen.
  always_comb begin
    lookup_o.valid   = lk_v_r;
    lookup_o.op      = lk_op_r;
    lookup_o.addr    = lk_addr_r;
    lookup_o.tag0    = lk_tag0_r;
    lookup_o.tag1    = lk_tag1_r;
    lookup_o.valid0  = lk_valid_r[0];
    lookup_o.valid1  = lk_valid_r[1];
    lookup_o.dirty0  = dirty_r[lk_addr_r.f.index][0];
    lookup_o.dirty1  = dirty_r[lk_addr_r.f.index][1];
    lookup_o.mru     = mru_r[lk_addr_r.f.index];
    lookup_o.hit     = hit0 | hit1;
    lookup_o.hit_way = hit1;
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    lk_v_r |-> !(hit0 && hit1));

endmodule

`default_nettype wire

// ==== hw/dma_engine.sv ====
// line transfer engine.
// one memory beat per word, each closed by an ack.
`default_nettype none
`timescale 1ns/1ns

`include "cache_defs.svh"

module dma_engine import dma_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  dma_cmd_s  cmd_i,
  output mem_beat_s mem_o,
  input  logic      mem_ack_i,
  output logic      done_o
);

  localparam int LGW = `CACHE_LG_BLOCK_WORDS;

  logic            busy_r;
  logic            write_r;
  logic [29-LGW:0] base_r;
  logic [LGW-1:0]  cnt_r;
  logic            start;
  logic            last_beat;

  assign start     = cmd_i.evict | cmd_i.fill;
  assign last_beat = &cnt_r;
  assign done_o    = busy_r & mem_ack_i & last_beat;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end else if (start) begin
      busy_r <= 1'b1;
      cnt_r  <= '0;
    end else if (busy_r && mem_ack_i) begin
      cnt_r <= cnt_r + 1'b1;
      if (last_beat) begin
        busy_r <= 1'b0;
      end
    end
  end

  // line base in words.
  always_ff @(posedge clk_i) begin
    if (start) begin
      write_r <= cmd_i.evict;
      base_r  <= cmd_i.line_addr[31:LGW+2];
    end
  end

  always_comb begin
    mem_o.valid     = busy_r;
    mem_o.write     = write_r;
    mem_o.word_addr = {base_r, cnt_r};
  end

  assert property (@(posedge clk_i) disable iff (rst_i) start |-> !busy_r);

endmodule

`default_nettype wire

// ==== hw/miss_fsm.sv ====
// miss and flush controller.
// picks victim or flush way, sequences evict and fill.
`default_nettype none
`timescale 1ns/1ns

`include "cache_defs.svh"

module miss_fsm import cache_pkg::*, dma_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  lookup_s                     lookup_i,
  input  logic                        wb_empty_i,
  input  logic                        dma_done_i,
  output dma_cmd_s                    dma_cmd_o,
  output store_commit_s               commit_o,
  output logic                        tag_we_o,
  output logic                        inval_o,
  output logic                        dirty_clr_o,
  output logic                        touch_o,
  output logic                        way_o,
  output logic [`CACHE_LG_SETS-1:0]   index_o,
  output logic [`CACHE_TAG_W-1:0]     tag_o,
  output logic                        busy_o,
  output logic                        done_o
);

  localparam int OFF_W = `CACHE_LG_BLOCK_WORDS + 2;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CHOOSE,
    S_FILL_ADDR,
    S_EVICT_ADDR,
    S_EVICT_DATA,
    S_FILL_DATA,
    S_RECOVER
  } state_e;

  state_e      state_r;
  state_e      state_n;
  logic        way_r;
  logic        way_n;
  logic        way_dirty_r;
  logic        way_valid_r;
  logic [31:0] evict_addr_r;
  logic        done_r;
  logic        done_n;
  logic        fill_op;
  logic        victim;
  logic        need_evict;

  assign fill_op = (lookup_i.op == OP_LD) | (lookup_i.op == OP_ST);

  // first invalid way, else the one not recently used.
  assign victim = !lookup_i.valid0 ? 1'b0 : (!lookup_i.valid1 ? 1'b1 : !lookup_i.mru);
  assign way_n = fill_op ? victim :
                 ((lookup_i.op == OP_TAGFL) ? lookup_i.addr.f.tag[0] : lookup_i.hit_way);

  assign need_evict = way_dirty_r & way_valid_r & (lookup_i.op != OP_AINV);

  assign way_o   = (state_r == S_IDLE) ? lookup_i.hit_way : way_r;
  assign index_o = lookup_i.addr.f.index;
  assign tag_o   = lookup_i.addr.f.tag;
  assign done_o  = done_r;
  assign busy_o  = lookup_i.valid | (state_r != S_IDLE) | done_r;

  // dirty bits are sampled once the buffer has drained.
  always_ff @(posedge clk_i) begin
    if (state_r == S_CHOOSE && wb_empty_i) begin
      way_r        <= way_n;
      way_dirty_r  <= way_n ? lookup_i.dirty1 : lookup_i.dirty0;
      way_valid_r  <= way_n ? lookup_i.valid1 : lookup_i.valid0;
      evict_addr_r <= {(way_n ? lookup_i.tag1 : lookup_i.tag0), lookup_i.addr.f.index,
                       OFF_W'(0)};
    end
  end

  always_comb begin
    state_n     = state_r;
    done_n      = 1'b0;
    tag_we_o    = 1'b0;
    inval_o     = 1'b0;
    dirty_clr_o = 1'b0;
    touch_o     = 1'b0;
    commit_o       = '0;
    commit_o.index = lookup_i.addr.f.index;
    commit_o.way   = way_o;
    dma_cmd_o      = '0;
    dma_cmd_o.line_addr = (state_r == S_EVICT_ADDR) ? evict_addr_r :
                          {lookup_i.addr.raw[31:OFF_W], OFF_W'(0)};

    case (state_r)
      S_IDLE: begin
        if (lookup_i.valid) begin
          if (fill_op) begin
            if (lookup_i.hit) begin
              touch_o        = (lookup_i.op == OP_LD);
              commit_o.valid = (lookup_i.op == OP_ST);
              done_n         = 1'b1;
            end else begin
              state_n = S_CHOOSE;
            end
          end else if (lookup_i.op == OP_TAGFL || lookup_i.hit) begin
            state_n = S_CHOOSE;
          end else begin
            done_n = 1'b1;
          end
        end
      end
      S_CHOOSE: begin
        if (wb_empty_i) begin
          state_n = S_EVICT_ADDR;
        end
      end
      S_EVICT_ADDR: begin
        if (need_evict) begin
          dma_cmd_o.evict = 1'b1;
          state_n         = S_EVICT_DATA;
        end else if (fill_op) begin
          state_n = S_FILL_ADDR;
        end else begin
          // clean line, only the invalidating ops act.
          inval_o = way_valid_r & ((lookup_i.op == OP_AINV) | (lookup_i.op == OP_AFLINV));
          state_n = S_RECOVER;
        end
      end
      S_EVICT_DATA: begin
        if (dma_done_i) begin
          if (fill_op) begin
            state_n = S_FILL_ADDR;
          end else begin
            inval_o     = (lookup_i.op == OP_AFLINV);
            dirty_clr_o = (lookup_i.op != OP_AFLINV);
            state_n     = S_RECOVER;
          end
        end
      end
      S_FILL_ADDR: begin
        dma_cmd_o.fill = 1'b1;
        state_n        = S_FILL_DATA;
      end
      S_FILL_DATA: begin
        if (dma_done_i) begin
          tag_we_o       = 1'b1;
          commit_o.valid = (lookup_i.op == OP_ST);
          state_n        = S_RECOVER;
        end
      end
      S_RECOVER: begin
        done_n  = 1'b1;
        state_n = S_IDLE;
      end
      default: state_n = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= S_IDLE;
      done_r  <= 1'b0;
    end else begin
      state_r <= state_n;
      done_r  <= done_n;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    !(dma_cmd_o.evict && dma_cmd_o.fill));

  assert property (@(posedge clk_i) disable iff (rst_i)
    (dma_cmd_o.evict || dma_cmd_o.fill) |-> wb_empty_i);

endmodule

`default_nettype wire

// ==== hw/miss_top.sv ====
// miss subsystem top.
// wires lookup, controller, write buffer and DMA.
`default_nettype none
`timescale 1ns/1ns

`include "cache_defs.svh"

module miss_top import cache_pkg::*, dma_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_v_i,
  input  cache_op_e   req_op_i,
  input  cache_addr_u req_addr_i,
  output mem_beat_s   mem_o,
  input  logic        mem_ack_i,
  output logic        busy_o,
  output logic        done_o
);

  lookup_s                   lookup;
  store_commit_s             commit;
  store_commit_s             wb_pop;
  logic                      wb_empty;
  dma_cmd_s                  dma_cmd;
  logic                      dma_done;
  logic                      tag_we;
  logic                      inval;
  logic                      dirty_clr;
  logic                      touch;
  logic                      way;
  logic [`CACHE_LG_SETS-1:0] index;
  logic [`CACHE_TAG_W-1:0]   tag;

  tag_status_mem u_tags (
    .clk_i, .rst_i, .req_v_i, .req_op_i, .req_addr_i,
    .lookup_o(lookup), .tag_we_i(tag_we), .inval_i(inval), .dirty_clr_i(dirty_clr),
    .touch_i(touch), .way_i(way), .index_i(index), .tag_i(tag), .wb_pop_i(wb_pop)
  );

  miss_fsm u_fsm (
    .clk_i, .rst_i, .lookup_i(lookup), .wb_empty_i(wb_empty), .dma_done_i(dma_done),
    .dma_cmd_o(dma_cmd), .commit_o(commit), .tag_we_o(tag_we), .inval_o(inval),
    .dirty_clr_o(dirty_clr), .touch_o(touch), .way_o(way), .index_o(index),
    .tag_o(tag), .busy_o, .done_o
  );

  write_buffer u_wb (
    .clk_i, .rst_i, .push_i(commit), .pop_o(wb_pop), .empty_o(wb_empty)
  );

  dma_engine u_dma (
    .clk_i, .rst_i, .cmd_i(dma_cmd), .mem_o, .mem_ack_i, .done_o(dma_done)
  );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// testbench clock source, 4 ns period.
`default_nettype none
`timescale 1ns/1ns

module clk_gen #(
  parameter int HALF_NS = 2
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_NS clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== bench/miss_tb.sv ====
// miss subsystem testbench with shadow tag model,
// random-delay memory responder, concurrent checks and timeout.
`default_nettype none
`timescale 1ns/1ns

`include "cache_defs.svh"

module miss_tb
  import cache_pkg::*, dma_pkg::*;
();

  localparam int SETS    = 1 << `CACHE_LG_SETS;
  localparam int WORDS   = 1 << `CACHE_LG_BLOCK_WORDS;
  localparam int OFF_W   = `CACHE_LG_BLOCK_WORDS + 2;
  localparam int N_FIXED = 19;
  localparam int N_RAND  = 40;
  localparam int N_REQ   = N_FIXED + N_RAND;
  localparam int TIMEOUT = N_REQ * 60;

  // tags 10 and 32 are even, 21 and 43 odd, all at index 3 unless noted.
  localparam logic [`CACHE_TAG_W-1:0] TAG_POOL [4] = '{'h10, 'h21, 'h32, 'h43};
  localparam logic [31:0] ADDR_A    = 32'h0000_1030;
  localparam logic [31:0] ADDR_B    = 32'h0000_2130;
  localparam logic [31:0] ADDR_C    = 32'h0000_3230;
  localparam logic [31:0] ADDR_ABS  = 32'h0000_4330;
  localparam logic [31:0] ADDR_D    = 32'h0000_4350;

  logic        clk;
  logic        rst;
  logic        req_v;
  cache_op_e   req_op;
  cache_addr_u req_addr;
  mem_beat_s   mem_beat;
  logic        mem_ack = 1'b0;
  logic        dut_busy;
  logic        dut_done;

  logic [`CACHE_TAG_W-1:0] m_tag [2][SETS];
  logic                    m_valid [2][SETS];
  logic                    m_dirty [2][SETS];
  logic                    m_mru [SETS];

  logic [30:0] exp_mem [1024];
  int          exp_wr;
  int          exp_rd;
  logic [30:0] exp_head;
  logic [30:0] got_beat;
  string       test_name;
  logic        quick;
  int          req_cnt;
  int          done_cnt;
  int          cycle_cnt = 0;
  int unsigned ack_wait;
  logic        rst_q = 1'b0;
  logic        req_q1;
  logic        req_q2;
  logic        open;
  logic        done_q;

  clk_gen u_clk (.clk_o(clk));

  miss_top UUT (
    .clk_i(clk), .rst_i(rst), .req_v_i(req_v), .req_op_i(req_op), .req_addr_i(req_addr),
    .mem_o(mem_beat), .mem_ack_i(mem_ack), .busy_o(dut_busy), .done_o(dut_done)
  );

  assign exp_head = exp_mem[exp_rd[9:0]];
  assign got_beat = {mem_beat.write, mem_beat.word_addr};

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  function automatic logic [31:0] line_base(input logic [`CACHE_TAG_W-1:0] tag,
                                            input logic [`CACHE_LG_SETS-1:0] idx);
    return {tag, idx, OFF_W'(0)};
  endfunction

  // one beat per word, consecutive from the line base.
  task automatic expect_line(input logic write, input logic [31:0] base);
    for (int i = 0; i < WORDS; i++) begin
      exp_mem[exp_wr[9:0]] = {write, base[31:2] + 30'(i)};
      exp_wr++;
    end
  endtask

  task automatic predict_request(input cache_op_e op, input cache_addr_u a);
    logic [`CACHE_LG_SETS-1:0] idx;
    logic [`CACHE_TAG_W-1:0]   t;
    logic                      hit0;
    logic                      hit1;
    logic                      w;
    idx   = a.f.index;
    t     = a.f.tag;
    hit0  = m_valid[0][idx] && (m_tag[0][idx] == t);
    hit1  = m_valid[1][idx] && (m_tag[1][idx] == t);
    quick = 1'b0;
    if (op == OP_LD || op == OP_ST) begin
      if (hit0 || hit1) begin
        quick      = 1'b1;
        m_mru[idx] = hit1;
        if (op == OP_ST)
          m_dirty[hit1][idx] = 1'b1;
      end else begin
        // invalid way first, else the one not recently used.
        w = !m_valid[0][idx] ? 1'b0 : (!m_valid[1][idx] ? 1'b1 : !m_mru[idx]);
        if (m_valid[w][idx] && m_dirty[w][idx])
          expect_line(1'b1, line_base(m_tag[w][idx], idx));
        expect_line(1'b0, line_base(t, idx));
        m_tag[w][idx]   = t;
        m_valid[w][idx] = 1'b1;
        m_dirty[w][idx] = (op == OP_ST);
        m_mru[idx]      = w;
      end
    end else if (op != OP_TAGFL && !(hit0 || hit1)) begin
      quick = 1'b1;
    end else begin
      w = (op == OP_TAGFL) ? t[0] : hit1;
      if (op != OP_AINV && m_valid[w][idx] && m_dirty[w][idx]) begin
        expect_line(1'b1, line_base(m_tag[w][idx], idx));
        m_dirty[w][idx] = 1'b0;
      end
      if (op == OP_AINV || op == OP_AFLINV) begin
        m_valid[w][idx] = 1'b0;
        m_dirty[w][idx] = 1'b0;
      end
    end
  endtask

  // strobe one request, then wait for done and for busy to drop.
  task automatic run_request(input cache_op_e op, input logic [31:0] addr, input string name);
    test_name = name;
    predict_request(op, addr);
    req_v        <= 1'b1;
    req_op       <= op;
    req_addr.raw <= addr;
    @(posedge clk);
    req_v <= 1'b0;
    while (!dut_done) @(posedge clk);
    while (dut_busy) @(posedge clk);
    req_cnt++;
  endtask

  // memory side acks each beat after 0 to 3 idle cycles.
  always @(posedge clk) begin
    if (rst) begin
      mem_ack  <= 1'b0;
      ack_wait <= 0;
    end else begin
      mem_ack <= 1'b0;
      if (mem_ack) begin
        ack_wait <= $urandom_range(3, 0);
      end else if (mem_beat.valid) begin
        if (ack_wait == 0)
          mem_ack <= 1'b1;
        else
          ack_wait <= ack_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      req_q1   <= 1'b0;
      req_q2   <= 1'b0;
      open     <= 1'b0;
      done_q   <= 1'b0;
      done_cnt <= 0;
      exp_rd   <= 0;
    end else begin
      req_q1 <= req_v;
      req_q2 <= req_q1;
      done_q <= dut_done;
      if (req_v)
        open <= 1'b1;
      else if (dut_done)
        open <= 1'b0;
      if (dut_done)
        done_cnt <= done_cnt + 1;
      if (mem_beat.valid && mem_ack)
        exp_rd <= exp_rd + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT)
      abort_run("run timed out before all requests completed");
  end

  assert property (@(posedge clk) rst_q |-> (!dut_busy && !dut_done && !mem_beat.valid))
    else abort_run("busy, done or a memory beat is high during reset");

  assert property (@(posedge clk) disable iff (rst) req_v |-> (!dut_busy && !open))
    else abort_run("request strobed while the previous one is still busy");

  assert property (@(posedge clk) disable iff (rst) dut_done |-> (open && !done_q))
    else abort_run($sformatf("%s gave an extra done pulse", test_name));

  // hits and missing address flushes finish one cycle after the lookup.
  assert property (@(posedge clk) disable iff (rst) (req_q2 && quick) |-> dut_done)
    else abort_run($sformatf("%s did not finish one cycle after its lookup", test_name));

  assert property (@(posedge clk) disable iff (rst) dut_done |-> (exp_rd == exp_wr))
    else abort_run($sformatf("%s finished with expected memory beats missing", test_name));

  assert property (@(posedge clk) disable iff (rst)
    (mem_beat.valid && mem_ack) |-> (exp_rd != exp_wr))
    else abort_run($sformatf("%s produced a memory beat that was not expected", test_name));

  assert property (@(posedge clk) disable iff (rst)
    (mem_beat.valid && mem_ack) |-> (got_beat == exp_head))
    else abort_run($sformatf("Mismatch %s expected %08h actual %08h", test_name,
                             $sampled(exp_head), $sampled(got_beat)));

  initial begin
    cache_op_e   r_op;
    cache_addr_u r_addr;
    void'($urandom(32'h74ed));
    rst          = 1'b1;
    req_v        = 1'b0;
    req_op       = OP_LD;
    req_addr.raw = '0;
    exp_wr       = 0;
    req_cnt      = 0;
    quick        = 1'b0;
    test_name    = "reset";
    for (int s = 0; s < SETS; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_dirty[0][s] = 1'b0;
      m_dirty[1][s] = 1'b0;
      m_mru[s]      = 1'b0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    run_request(OP_LD, ADDR_A, "load_empty");
    run_request(OP_ST, ADDR_A + 8, "store_hit_a");
    run_request(OP_LD, ADDR_B, "load_fill_b");
    run_request(OP_LD, ADDR_B + 4, "load_hit_b");
    run_request(OP_LD, ADDR_C, "load_evict_dirty");
    run_request(OP_ST, ADDR_C + 12, "store_hit_c");
    run_request(OP_AFL, ADDR_C, "afl_dirty");
    run_request(OP_AFL, ADDR_C, "afl_repeat");
    run_request(OP_ST, ADDR_B, "store_hit_b");
    run_request(OP_TAGFL, ADDR_B, "tagfl_dirty");
    run_request(OP_TAGFL, ADDR_B, "tagfl_repeat");
    run_request(OP_ST, ADDR_C + 4, "store_before_ainv");
    run_request(OP_AINV, ADDR_C, "ainv");
    run_request(OP_LD, ADDR_C, "load_after_ainv");
    run_request(OP_ST, ADDR_C + 4, "store_before_aflinv");
    run_request(OP_AFLINV, ADDR_C, "aflinv_dirty");
    run_request(OP_LD, ADDR_C, "load_after_aflinv");
    run_request(OP_AFL, ADDR_ABS, "afl_miss");
    run_request(OP_ST, ADDR_D, "store_miss");

    // conflicting lines in two sets.
    for (int n = 0; n < N_RAND; n++) begin
      r_op            = cache_op_e'($urandom_range(5, 0));
      r_addr.raw      = line_base(TAG_POOL[$urandom_range(3, 0)],
                                  `CACHE_LG_SETS'($urandom_range(1, 0) != 0 ? 5 : 3));
      r_addr.f.offset = OFF_W'($urandom_range(WORDS * 4 - 1, 0));
      run_request(r_op, r_addr.raw, "random");
    end

    if (exp_rd == exp_wr && done_cnt == N_REQ && req_cnt == N_REQ) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("run ended with memory beats or done pulses missing");
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/cache_pkg.sv
hw/dma_pkg.sv
hw/write_buffer.sv
hw/tag_status_mem.sv
hw/dma_engine.sv
hw/miss_fsm.sv
hw/miss_top.sv
bench/clk_gen.sv
bench/miss_tb.sv

// ==== Makefile ====
# Verilator build and run of the miss subsystem testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

obj_dir/Vmiss_tb: list.f $(wildcard hw/*.sv hw/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module miss_tb -Mdir obj_dir

test: obj_dir/Vmiss_tb
	-./obj_dir/Vmiss_tb | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
